//--- rtl/i2cPkg.sv
/*
 * Shared types and register map of the APB I2C master
 * 7-bit addressing only, single master, no slave mode
 * Prescale and timeout are 14 bits wide
 * Status word sits in the low 5 bits of the status register
 */
`default_nettype none

package i2cPkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// Width of the prescale and timeout registers
	localparam int I2C_PRESCALE_W = 14;

	//////////////////////////////////////////////////
	// Commands
	//////////////////////////////////////////////////

	// Command opcodes, PWDATA[10:8] on a TX write
	typedef enum logic [2:0] {
		OP_START_WRITE = 3'd0,
		OP_WRITE       = 3'd1,
		OP_READ_ACK    = 3'd2,
		OP_READ_NACK   = 3'd3,
		OP_STOP        = 3'd4
	} i2cOpE;

	// TX FIFO word
	typedef struct packed {
		i2cOpE      op;
		logic [7:0] data;
	} i2cCmdT;

	// RX FIFO word
	typedef struct packed {
		logic [7:0] data;
	} i2cRxT;

	// Bus timing config, prescale is the quarter-bit period minus one
	typedef struct packed {
		logic [I2C_PRESCALE_W-1:0] prescale;
		logic [I2C_PRESCALE_W-1:0] timeout;
	} i2cCfgT;

	// Status word, busy in bit 4 down to rxEmpty in bit 0
	typedef struct packed {
		logic busy;
		logic error;
		logic txEmpty;
		logic txFull;
		logic rxEmpty;
	} i2cStatT;

	//////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////

	localparam logic [31:0] ADDR_TX   = 32'd0;
	localparam logic [31:0] ADDR_RX   = 32'd4;
	localparam logic [31:0] ADDR_CFG  = 32'd8;
	localparam logic [31:0] ADDR_TMO  = 32'd12;
	localparam logic [31:0] ADDR_STAT = 32'd16;

endpackage

`default_nettype wire

//--- rtl/syncFifo.sv
/*
 * Synchronous FIFO with first-word-fall-through head
 * Any Depth of 1 or more, power of two not needed
 * Push into full and pop from empty are ignored
 * headData is only meaningful while empty is low
 */
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
	parameter int  Depth = 8,
	parameter type DataT = logic [7:0]
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic push,
	input  DataT pushData,
	input  logic pop,
	output DataT headData,
	output logic empty,
	output logic full
);

	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntW = $clog2(Depth + 1);

	DataT mem [Depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic doPush;
	logic doPop;

	// Wrap at Depth, not at the pointer width
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	// Pointers and occupancy
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge PCLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	assign headData = mem[rdPtr];
	assign empty = (count == '0);
	assign full  = (count == CntW'(Depth));

endmodule

`default_nettype wire

//--- rtl/apbRegs.sv
/*
 * APB3 slave for the I2C master
 * Zero wait states, PREADY is high in every access phase
 * PSLVERR on unmapped address, TX write when full, RX read when empty,
 * or any access while the error is set (status write excepted)
 * A failing access changes no state
 * Error is sticky until the host writes the status address
 */
`timescale 1ns/1ps
`default_nettype none

module apbRegs (
	input  logic                PCLK,
	input  logic                PRESETn,
	// APB side
	input  logic                PSEL,
	input  logic                PENABLE,
	input  logic                PWRITE,
	input  logic [31:0]         PADDR,
	input  logic [31:0]         PWDATA,
	output logic [31:0]         PRDATA,
	output logic                PREADY,
	output logic                PSLVERR,
	// FIFO side
	input  i2cPkg::i2cRxT       rxHead,
	input  logic                txEmpty,
	input  logic                txFull,
	input  logic                rxEmpty,
	output logic                txPush,
	output i2cPkg::i2cCmdT      txCmd,
	output logic                rxPop,
	// Engine side
	input  logic                busy,
	input  logic                errSet,
	output i2cPkg::i2cCfgT      cfg,
	// Interrupts
	output logic                intTx,
	output logic                intRx
);

	logic access;
	logic isTx, isRx, isCfg, isTmo, isStat;
	logic mapped;
	logic statClear;
	logic accErr;
	logic goodAcc;
	logic errSticky;
	i2cPkg::i2cCfgT cfgReg;
	i2cPkg::i2cStatT stat;

	//////////////////////////////////////////////////
	// Access decode
	//////////////////////////////////////////////////

	// Access phase only, no wait states
	assign access = PSEL && PENABLE;
	assign PREADY = access;

	assign isTx   = (PADDR == i2cPkg::ADDR_TX);
	assign isRx   = (PADDR == i2cPkg::ADDR_RX);
	assign isCfg  = (PADDR == i2cPkg::ADDR_CFG);
	assign isTmo  = (PADDR == i2cPkg::ADDR_TMO);
	assign isStat = (PADDR == i2cPkg::ADDR_STAT);
	assign mapped = isTx || isRx || isCfg || isTmo || isStat;

	// Status write is the way out of a sticky error
	assign statClear = access && PWRITE && isStat;

	// All slave error decisions in one place
	assign accErr = !mapped
		|| (PWRITE && isTx && txFull)
		|| (!PWRITE && isRx && rxEmpty)
		|| (errSticky && !statClear);

	assign PSLVERR = access && accErr;
	assign goodAcc = access && !accErr;

	// FIFO strobes only on a clean access
	assign txPush = goodAcc && PWRITE && isTx;
	assign rxPop  = goodAcc && !PWRITE && isRx;
	assign txCmd  = i2cPkg::i2cCmdT'(PWDATA[10:0]);

	//////////////////////////////////////////////////
	// Config, timeout and sticky error
	//////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfgReg <= '0;
		end
		else if (goodAcc && PWRITE)
		begin
			if (isCfg)
				cfgReg.prescale <= PWDATA[i2cPkg::I2C_PRESCALE_W-1:0];
			if (isTmo)
				cfgReg.timeout <= PWDATA[i2cPkg::I2C_PRESCALE_W-1:0];
		end
	end

	assign cfg = cfgReg;

	// Engine error wins over a clear in the same cycle
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
			errSticky <= 1'b0;
		else if (errSet)
			errSticky <= 1'b1;
		else if (statClear)
			errSticky <= 1'b0;
	end

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////

	assign stat = '{busy: busy, error: errSticky, txEmpty: txEmpty,
		txFull: txFull, rxEmpty: rxEmpty};

	always_comb
	begin
		case (PADDR)
			i2cPkg::ADDR_RX:   PRDATA = {24'd0, rxHead};
			i2cPkg::ADDR_CFG:  PRDATA = 32'(cfgReg.prescale);
			i2cPkg::ADDR_TMO:  PRDATA = 32'(cfgReg.timeout);
			i2cPkg::ADDR_STAT: PRDATA = {27'd0, stat};
			// TX is write only
			default:           PRDATA = 32'd0;
		endcase
	end

	// Interrupts follow the empty flags
	assign intTx = txEmpty;
	assign intRx = rxEmpty;

endmodule

`default_nettype wire

//--- rtl/i2cMaster.sv
/*
 * I2C bit engine fed from the TX command FIFO
 * One bit is four quarters of prescale+1 cycles, SCL low then high
 * A quarter with SCL released stalls while a slave holds SCL low
 * Error on NACK, stretch timeout or RX overflow, then stop and
 * drop commands up to and including the next OP_STOP
 * sclIn and sdaIn must be synchronous to PCLK
 */
`timescale 1ns/1ps
`default_nettype none

module i2cMaster (
	input  logic           PCLK,
	input  logic           PRESETn,
	input  i2cPkg::i2cCfgT cfg,
	// Command FIFO
	input  i2cPkg::i2cCmdT cmd,
	input  logic           cmdEmpty,
	output logic           cmdPop,
	// Receive FIFO
	input  logic           rxFull,
	output logic           rxPush,
	output i2cPkg::i2cRxT  rxData,
	// Status
	output logic           busy,
	output logic           errSet,
	// Open-drain pins, Oe high pulls low
	input  logic           sclIn,
	input  logic           sdaIn,
	output logic           sclOe,
	output logic           sdaOe
);

	typedef enum logic [2:0] {IDLE, START, BIT, ACK, STOP, HOLD} stateE;

	stateE state;
	logic [1:0] quarter;
	logic [i2cPkg::I2C_PRESCALE_W-1:0] qCnt;
	logic [i2cPkg::I2C_PRESCALE_W-1:0] stretchCnt;
	logic [2:0] bitCnt;
	logic [7:0] shiftReg;
	logic isRead;
	logic ackOut;
	logic drop;
	logic stall;
	logic tick;
	logic timedOut;

	// Slave holding SCL low while we released it
	assign stall = (state != IDLE) && (state != HOLD) && !sclOe && !sclIn;
	assign tick = !stall && (qCnt == cfg.prescale);
	// timeout+1 stall cycles
	assign timedOut = stall && (stretchCnt == cfg.timeout);

	assign cmdPop = ((state == IDLE) || (state == HOLD)) && !cmdEmpty;
	assign busy = (state != IDLE) || !cmdEmpty;

	//////////////////////////////////////////////////
	// Quarter timing and stretch counter
	//////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			qCnt <= '0;
			quarter <= 2'd0;
			stretchCnt <= '0;
		end
		else
		begin
			stretchCnt <= stall ? stretchCnt + 1'b1 : '0;
			if ((state == IDLE) || (state == HOLD) || timedOut)
			begin
				qCnt <= '0;
				quarter <= 2'd0;
			end
			else if (tick)
			begin
				qCnt <= '0;
				quarter <= quarter + 2'd1;
			end
			else if (!stall)
				qCnt <= qCnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Byte data path
	//////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (cmdPop)
		begin
			shiftReg <= cmd.data;
			isRead <= (cmd.op == i2cPkg::OP_READ_ACK) || (cmd.op == i2cPkg::OP_READ_NACK);
			ackOut <= (cmd.op == i2cPkg::OP_READ_ACK);
		end
		// Sample mid-high, also recirculates the write byte
		else if ((state == BIT) && tick && (quarter == 2'd2))
			shiftReg <= {shiftReg[6:0], sdaIn};
		if ((state == ACK) && tick && (quarter == 2'd2))
			rxData <= i2cPkg::i2cRxT'(shiftReg);
	end

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= IDLE;
			bitCnt <= 3'd0;
			drop <= 1'b0;
			sclOe <= 1'b0;
			sdaOe <= 1'b0;
			rxPush <= 1'b0;
			errSet <= 1'b0;
		end
		else
		begin
			rxPush <= 1'b0;
			errSet <= 1'b0;
			if (timedOut)
			begin
				// Give up, stop once, a timeout inside stop just frees the bus
				errSet <= 1'b1;
				drop <= 1'b1;
				sdaOe <= 1'b0;
				sclOe <= (state != STOP);
				state <= (state == STOP) ? IDLE : STOP;
			end
			else
			begin
				case (state)
					IDLE:
						if (!cmdEmpty)
						begin
							if (drop)
							begin
								if (cmd.op == i2cPkg::OP_STOP)
									drop <= 1'b0;
							end
							else if (cmd.op == i2cPkg::OP_START_WRITE)
								state <= START;
							// Data on a free bus is a host error
							else if (cmd.op != i2cPkg::OP_STOP)
							begin
								errSet <= 1'b1;
								drop <= 1'b1;
							end
						end
					// Bus owned, SCL held low
					HOLD:
						if (!cmdEmpty)
						begin
							case (cmd.op)
								i2cPkg::OP_START_WRITE: state <= START;
								i2cPkg::OP_STOP:        state <= STOP;
								default:
								begin
									state <= BIT;
									bitCnt <= 3'd7;
								end
							endcase
						end
					// Start or repeated start
					START:
						if (tick)
						begin
							case (quarter)
								2'd0: sdaOe <= 1'b0;
								2'd1: sclOe <= 1'b0;
								2'd2: sdaOe <= 1'b1;
								default:
								begin
									sclOe <= 1'b1;
									bitCnt <= 3'd7;
									state <= BIT;
								end
							endcase
						end
					// MSB first
					BIT:
						if (tick)
						begin
							case (quarter)
								2'd0: sdaOe <= isRead ? 1'b0 : !shiftReg[7];
								2'd1: sclOe <= 1'b0;
								2'd2: ;
								default:
								begin
									sclOe <= 1'b1;
									if (bitCnt == 3'd0)
										state <= ACK;
									else
										bitCnt <= bitCnt - 3'd1;
								end
							endcase
						end
					ACK:
						if (tick)
						begin
							case (quarter)
								2'd0: sdaOe <= isRead && ackOut;
								2'd1: sclOe <= 1'b0;
								2'd2:
									if (isRead ? rxFull : sdaIn)
									begin
										// Overflow or NACK
										errSet <= 1'b1;
										drop <= 1'b1;
									end
									else
										rxPush <= isRead;
								default:
								begin
									sclOe <= 1'b1;
									state <= drop ? STOP : HOLD;
								end
							endcase
						end
					// SDA rises while SCL is high
					STOP:
						if (tick)
						begin
							case (quarter)
								2'd0: sdaOe <= 1'b1;
								2'd1: sclOe <= 1'b0;
								2'd2: sdaOe <= 1'b0;
								default: state <= IDLE;
							endcase
						end
					default: state <= IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/i2cApbTop.sv
/*
 * APB3 attached I2C master, top level
 * TxDepth and RxDepth set the command and receive FIFO sizes
 * Pins are open drain, the board provides pull-ups
 */
`timescale 1ns/1ps
`default_nettype none

module i2cApbTop #(
	parameter int TxDepth = 8,
	parameter int RxDepth = 8
) (
	input  logic        PCLK,
	input  logic        PRESETn,
	input  logic        PSEL,
	input  logic        PENABLE,
	input  logic        PWRITE,
	input  logic [31:0] PADDR,
	input  logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic        PREADY,
	output logic        PSLVERR,
	output logic        sclOe,
	output logic        sdaOe,
	input  logic        sclIn,
	input  logic        sdaIn,
	output logic        intTx,
	output logic        intRx
);

	// Command path
	i2cPkg::i2cCmdT txCmd;
	i2cPkg::i2cCmdT txHead;
	logic txPush, txPop, txEmpty, txFull;
	// Receive path
	i2cPkg::i2cRxT rxData;
	i2cPkg::i2cRxT rxHead;
	logic rxPush, rxPop, rxEmpty, rxFull;
	// Engine control
	i2cPkg::i2cCfgT cfg;
	logic busy, errSet;

	apbRegs regs (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.rxHead(rxHead), .txEmpty(txEmpty), .txFull(txFull), .rxEmpty(rxEmpty),
		.txPush(txPush), .txCmd(txCmd), .rxPop(rxPop),
		.busy(busy), .errSet(errSet), .cfg(cfg),
		.intTx(intTx), .intRx(intRx)
	);

	// Host to engine
	syncFifo #(.Depth(TxDepth), .DataT(i2cPkg::i2cCmdT)) txFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(txPush), .pushData(txCmd), .pop(txPop),
		.headData(txHead), .empty(txEmpty), .full(txFull)
	);

	// Engine to host
	syncFifo #(.Depth(RxDepth), .DataT(i2cPkg::i2cRxT)) rxFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(rxPush), .pushData(rxData), .pop(rxPop),
		.headData(rxHead), .empty(rxEmpty), .full(rxFull)
	);

	i2cMaster engine (
		.PCLK(PCLK), .PRESETn(PRESETn), .cfg(cfg),
		.cmd(txHead), .cmdEmpty(txEmpty), .cmdPop(txPop),
		.rxFull(rxFull), .rxPush(rxPush), .rxData(rxData),
		.busy(busy), .errSet(errSet),
		.sclIn(sclIn), .sdaIn(sdaIn), .sclOe(sclOe), .sdaOe(sdaOe)
	);

endmodule

`default_nettype wire

//--- tb/i2cSlaveModel.sv
/*
 * Behavioral I2C slave, 7-bit address given by Addr
 * ACKs its address and every written byte, 16-byte memory
 * Memory pointer restarts at every start condition
 * Holds SCL low for stretchNs after each falling SCL edge while addressed
 */
`timescale 1ns/1ps
`default_nettype none

module i2cSlaveModel #(
	parameter logic [6:0] Addr = 7'h50
) (
	input  logic scl,
	input  logic sda,
	input  int   stretchNs,
	output logic sclLow,
	output logic sdaLow
);

	typedef enum {S_ADDR, S_WRITE, S_READ, S_IDLE} phaseE;

	logic [7:0] mem [16];
	logic [7:0] shift;
	logic [7:0] rdByte;
	int bitCnt;
	int ptr;
	logic active;
	logic slaveAcking;
	logic nack;
	logic sclPrev;
	logic sdaPrev;
	phaseE phase;

	initial
	begin
		sclLow = 1'b0;
		sdaLow = 1'b0;
		active = 1'b0;
		slaveAcking = 1'b0;
		nack = 1'b0;
		sclPrev = 1'b1;
		sdaPrev = 1'b1;
		bitCnt = 0;
		ptr = 0;
		phase = S_IDLE;
	end

	//////////////////////////////////////////////////
	// Bus events
	//////////////////////////////////////////////////

	always @(scl or sda)
	begin
		// Start or repeated start, SDA falls with SCL high
		if (scl && sclPrev && sdaPrev && !sda)
		begin
			active = 1'b1;
			phase = S_ADDR;
			bitCnt = 0;
			ptr = 0;
			sdaLow = 1'b0;
			slaveAcking = 1'b0;
		end
		// Stop, SDA rises with SCL high
		else if (scl && sclPrev && !sdaPrev && sda)
		begin
			active = 1'b0;
			sdaLow = 1'b0;
		end
		// Rising SCL samples data or the master's ACK
		else if (active && scl && !sclPrev)
		begin
			if (bitCnt < 8)
			begin
				if (phase != S_READ)
					shift = {shift[6:0], sda};
				bitCnt++;
			end
			else if (bitCnt == 8)
			begin
				if (!slaveAcking)
					nack = sda;
				bitCnt = 9;
			end
		end
		// Falling SCL changes what the slave drives
		else if (active && !scl && sclPrev)
		begin
			if (bitCnt == 8)
			begin
				if (phase == S_ADDR)
				begin
					if (shift[7:1] == Addr)
					begin
						sdaLow = 1'b1;
						slaveAcking = 1'b1;
						nack = 1'b0;
						phase = shift[0] ? S_READ : S_WRITE;
					end
					else
						active = 1'b0;
				end
				else if (phase == S_WRITE)
				begin
					mem[ptr[3:0]] = shift;
					ptr++;
					sdaLow = 1'b1;
					slaveAcking = 1'b1;
				end
				else
				begin
					// Master owns the ACK bit of a read
					sdaLow = 1'b0;
					slaveAcking = 1'b0;
				end
			end
			else if (bitCnt == 9)
			begin
				sdaLow = 1'b0;
				bitCnt = 0;
				slaveAcking = 1'b0;
				if (phase == S_READ)
				begin
					if (nack)
						phase = S_IDLE;
					else
					begin
						rdByte = mem[ptr[3:0]];
						ptr++;
						sdaLow = !rdByte[7];
					end
				end
			end
			else if ((phase == S_READ) && (bitCnt > 0))
				sdaLow = !rdByte[7 - bitCnt];
		end
		sclPrev = scl;
		sdaPrev = sda;
	end

	// Clock stretch after each falling edge
	always @(negedge scl)
	begin
		if (active && (stretchNs > 0))
		begin
			sclLow = 1'b1;
			#(stretchNs);
			sclLow = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- tb/i2cApbChecker.sv
/*
 * Concurrent assertions on the APB slave, bound into apbRegs
 * Checked only while out of reset
 */
`timescale 1ns/1ps
`default_nettype none

module i2cApbChecker (
	input logic PCLK,
	input logic PRESETn,
	input logic PSEL,
	input logic PENABLE,
	input logic PREADY,
	input logic PSLVERR,
	input logic txPush,
	input logic rxPop,
	input logic txEmpty,
	input logic rxEmpty,
	input logic intTx,
	input logic intRx
);

	// Number of assertion failures so far
	int failCount;

	initial
		failCount = 0;

	// No wait states and no stray ready
	readyInAccess: assert property (@(posedge PCLK) disable iff (!PRESETn)
		PREADY |-> (PSEL && PENABLE))
	else
	begin
		$error("PREADY high outside an access phase");
		failCount++;
	end

	intFollowsEmpty: assert property (@(posedge PCLK) disable iff (!PRESETn)
		(intTx == txEmpty) && (intRx == rxEmpty))
	else
	begin
		$error("Interrupt differs from its FIFO empty flag");
		failCount++;
	end

	// A failing access moves no FIFO
	noStrobeOnError: assert property (@(posedge PCLK) disable iff (!PRESETn)
		PSLVERR |-> (!txPush && !rxPop))
	else
	begin
		$error("FIFO strobe during a PSLVERR access");
		failCount++;
	end

endmodule

bind apbRegs i2cApbChecker apbCheck (
	.PCLK(PCLK), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE),
	.PREADY(PREADY), .PSLVERR(PSLVERR), .txPush(txPush), .rxPop(rxPop),
	.txEmpty(txEmpty), .rxEmpty(rxEmpty), .intTx(intTx), .intRx(intRx)
);

`default_nettype wire

//--- tb/tbI2cApb.sv
/*
 * Testbench for the APB I2C master
 * Operations and expected values come from tb/i2cApbTestdata.txt
 * APB inputs change on the falling edge, results sampled 1 ns later
 * Watchdog limit scales with the number of operations and the largest prescale
 */
`timescale 1ns/1ps
`default_nettype none

module tbI2cApb;

	localparam int TxDepth = 8;
	localparam int RxDepth = 8;
	localparam int PollLimit = 20000;

	logic PCLK;
	logic PRESETn;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic sclOe;
	logic sdaOe;
	logic intTx;
	logic intRx;
	logic scl;
	logic sda;
	logic slvScl;
	logic slvSda;
	int stretchNs;

	// Operation table
	string tName[$];
	string tOp[$];
	logic [31:0] tAddr[$];
	logic [31:0] tData[$];
	logic [31:0] tExp[$];
	logic tErr[$];

	int errors;
	int checks;
	int tests;
	int testErrs;
	string curTest;
	logic loaded;
	longint wdNs;

	i2cApbTop #(.TxDepth(TxDepth), .RxDepth(RxDepth)) i_dut (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.sclOe(sclOe), .sdaOe(sdaOe), .sclIn(scl), .sdaIn(sda),
		.intTx(intTx), .intRx(intRx)
	);

	i2cSlaveModel #(.Addr(7'h50)) slave (
		.scl(scl), .sda(sda), .stretchNs(stretchNs),
		.sclLow(slvScl), .sdaLow(slvSda)
	);

	// Wired-AND with pull-up
	assign scl = !(sclOe || slvScl);
	assign sda = !(sdaOe || slvSda);

	always #5 PCLK = !PCLK;

	//////////////////////////////////////////////////
	// APB driver
	//////////////////////////////////////////////////

	task automatic apbXfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge PCLK);
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = wr;
		PADDR = addr;
		PWDATA = wdata;
		@(negedge PCLK);
		PENABLE = 1'b1;
		// Access phase settled
		#1;
		rdata = PRDATA;
		err = PSLVERR;
		// No wait states
		checkErr("PREADY", PREADY, 1'b1);
		@(negedge PCLK);
		PSEL = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] wdata, output logic err);
		logic [31:0] unused;
		apbXfer(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apbRead(input logic [31:0] addr, output logic [31:0] rdata, output logic err);
		apbXfer(1'b0, addr, 32'd0, rdata, err);
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic checkData(input string sig, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("Mismatch %s in %s: got 0x%08h expected 0x%08h", sig, curTest, got, exp);
			errors++;
			testErrs++;
		end
	endtask

	task automatic checkStat(input i2cPkg::i2cStatT got, input i2cPkg::i2cStatT exp);
		checks++;
		if (got !== exp)
		begin
			$display("Mismatch status in %s: got 0x%02h expected 0x%02h", curTest, got, exp);
			errors++;
			testErrs++;
		end
	endtask

	task automatic checkErr(input string sig, input bit got, input bit exp);
		checks++;
		if (got !== exp)
		begin
			$display("Mismatch %s in %s: got 0x%0h expected 0x%0h", sig, curTest, got, exp);
			errors++;
			testErrs++;
		end
	endtask

	// Poll status until idle, or until the TX FIFO drained
	task automatic pollStatus(input bit forTx);
		logic [31:0] d;
		logic e;
		i2cPkg::i2cStatT s;
		bit done;
		done = 1'b0;
		for (int n = 0; (n < PollLimit) && !done; n++)
		begin
			apbRead(i2cPkg::ADDR_STAT, d, e);
			s = i2cPkg::i2cStatT'(d[4:0]);
			done = forTx ? s.txEmpty : !s.busy;
		end
		if (!done)
		begin
			$display("Error in %s: engine did not settle after %0d status polls", curTest,
				PollLimit);
			errors++;
			testErrs++;
		end
	endtask

	//////////////////////////////////////////////////
	// Test data and sequencing
	//////////////////////////////////////////////////

	task automatic loadTable();
		int fd;
		int n;
		string line;
		string nm;
		string op;
		logic [31:0] a, dt, ex, er;
		logic [31:0] maxPre;
		maxPre = 0;
		fd = $fopen("tb/i2cApbTestdata.txt", "r");
		if (fd == 0)
		begin
			$display("Error: cannot open the test data file");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				// Skip comments and blank lines
				if ((line.len() > 1) && (line[0] != "#"))
				begin
					n = $sscanf(line, "%s %s %h %h %h %h", nm, op, a, dt, ex, er);
					if (n == 6)
					begin
						tName.push_back(nm);
						tOp.push_back(op);
						tAddr.push_back(a);
						tData.push_back(dt);
						tExp.push_back(ex);
						tErr.push_back(er[0]);
						if ((op == "write") && (a == i2cPkg::ADDR_CFG) && (dt > maxPre))
							maxPre = dt;
					end
				end
			end
			$fclose(fd);
		end
		// 40 bit times per operation, 4 quarters of prescale+1 cycles
		wdNs = longint'(tName.size()) * 40 * (longint'(maxPre) + 1) * 4 * 10;
		if (wdNs < 100000)
			wdNs = 100000;
	endtask

	task automatic finishTest();
		if (curTest != "")
		begin
			tests++;
			$display("test %-10s %s", curTest, (testErrs == 0) ? "ok" : "FAILED");
		end
	endtask

	task automatic runOp(input int i);
		logic [31:0] d;
		logic e;
		case (tOp[i])
			"write":
			begin
				apbWrite(tAddr[i], tData[i], e);
				checkErr("PSLVERR", e, tErr[i]);
			end
			"read":
			begin
				apbRead(tAddr[i], d, e);
				checkErr("PSLVERR", e, tErr[i]);
				if (tAddr[i] == i2cPkg::ADDR_STAT)
					checkStat(i2cPkg::i2cStatT'(d[4:0]), i2cPkg::i2cStatT'(tExp[i][4:0]));
				// RX head holds no defined byte while the FIFO is empty
				else if (!(tErr[i] && (tAddr[i] == i2cPkg::ADDR_RX)))
					checkData("PRDATA", d, tExp[i]);
			end
			"waitIdle": pollStatus(1'b0);
			"waitTx":   pollStatus(1'b1);
			"stretch":  stretchNs = int'(tData[i]);
			// Bytes written to the slave in its last transaction
			"count":    checkData("slave count", 32'(slave.ptr), tExp[i]);
			default:
			begin
				$display("Error in %s: unknown operation %s", curTest, tOp[i]);
				errors++;
				testErrs++;
			end
		endcase
	endtask

	initial
	begin
		PCLK = 1'b0;
		PRESETn = 1'b0;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = 32'd0;
		PWDATA = 32'd0;
		stretchNs = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		testErrs = 0;
		curTest = "";
		loaded = 1'b0;
		loadTable();
		loaded = 1'b1;
		repeat (8) @(posedge PCLK);
		@(negedge PCLK);
		PRESETn = 1'b1;
		// Pins and interrupts out of reset
		curTest = "resetPins";
		#1;
		checkErr("intTx", intTx, 1'b1);
		checkErr("intRx", intRx, 1'b1);
		checkErr("scl", scl, 1'b1);
		checkErr("sda", sda, 1'b1);
		finishTest();
		curTest = "";
		for (int i = 0; i < tName.size(); i++)
		begin
			if (tName[i] != curTest)
			begin
				finishTest();
				curTest = tName[i];
				testErrs = 0;
			end
			runOp(i);
		end
		finishTest();
		// Assertion failures of the bound APB checker
		if (i_dut.regs.apbCheck.failCount != 0)
		begin
			$display("Error: the APB checker saw %0d assertion failures",
				i_dut.regs.apbCheck.failCount);
			errors += i_dut.regs.apbCheck.failCount;
		end
		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (loaded);
		#(wdNs);
		$display("Timeout: the run did not finish within %0d ns", wdNs);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/i2cApbTestdata.txt
# test op addr data expect pslverr, all numbers hex
# ops: write read waitIdle waitTx stretch(data=ns) count(expect=slave bytes)
reset read 10 0 05 0
reset read 8 0 0 0
reset read c 0 0 0
regs write 8 3 0 0
regs write c 28 0 0
regs read 8 0 3 0
regs read c 0 28 0
regs read 20 0 0 1
regs read 4 0 0 1
regs read 10 0 05 0
wrRd write 0 0a0 0 0
wrRd write 0 112 0 0
wrRd write 0 134 0 0
wrRd write 0 400 0 0
wrRd waitIdle 0 0 0 0
wrRd read 10 0 05 0
wrRd count 0 0 2 0
wrRd write 0 0a1 0 0
wrRd write 0 200 0 0
wrRd write 0 300 0 0
wrRd write 0 400 0 0
wrRd waitIdle 0 0 0 0
wrRd read 10 0 04 0
wrRd read 4 0 12 0
wrRd read 4 0 34 0
wrRd read 10 0 05 0
nack write 0 0b0 0 0
nack write 0 111 0 0
nack write 0 400 0 0
nack waitIdle 0 0 0 0
nack read 10 0 0d 1
nack read 8 0 3 1
nack write 10 0 0 0
nack read 10 0 05 0
nack write 0 0a0 0 0
nack write 0 156 0 0
nack write 0 400 0 0
nack waitIdle 0 0 0 0
nack read 10 0 05 0
nack count 0 0 1 0
stretch stretch 0 c8 0 0
stretch write 0 0a0 0 0
stretch write 0 177 0 0
stretch write 0 400 0 0
stretch waitIdle 0 0 0 0
stretch read 10 0 05 0
stretch count 0 0 1 0
stretch stretch 0 320 0 0
stretch write 0 0a0 0 0
stretch write 0 188 0 0
stretch write 0 400 0 0
stretch waitIdle 0 0 0 0
stretch read 10 0 0d 1
stretch write 10 0 0 0
stretch stretch 0 0 0 0
stretch read 10 0 05 0
fifo write 8 9 0 0
fifo write 0 0a0 0 0
fifo write 0 101 0 0
fifo write 0 102 0 0
fifo write 0 103 0 0
fifo write 0 104 0 0
fifo write 0 105 0 0
fifo write 0 106 0 0
fifo write 0 107 0 0
fifo write 0 108 0 0
fifo write 0 109 0 1
fifo read 10 0 13 0
fifo waitTx 0 0 0 0
fifo write 0 400 0 0
fifo waitIdle 0 0 0 0
fifo read 10 0 05 0
fifo count 0 0 8 0

//--- tb.f
rtl/i2cPkg.sv
rtl/syncFifo.sv
rtl/apbRegs.sv
rtl/i2cMaster.sv
rtl/i2cApbTop.sv
tb/i2cSlaveModel.sv
tb/i2cApbChecker.sv
tb/tbI2cApb.sv

//--- run.sh
#!/bin/sh
# Build and run the APB I2C master testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tbI2cApb -f tb.f -o simv

# The log decides the result, so a nonzero simulator exit is not fatal here
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
	echo "RESULT: PASS"
	exit 0
fi
echo "RESULT: FAIL"
exit 1
